//--- vlog.f
source/npu_pkg.sv
source/npu_fetch.sv
source/npu_regfile.sv
source/npu_dma_engine.sv
source/npu_control.sv
source/npu_core.sv
testbench/npu_core_properties.sv
testbench/tb_npu_core.sv

//--- run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_npu_core \
    -f vlog.f -o tb_npu_core > sim.log 2>&1 &&
    ./obj_dir/tb_npu_core >> sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

//--- testbench/tb_npu_core.sv
`timescale 1ns/1ps

module tb_npu_core
    import npu_pkg::*;
();

    // 38 beats of about ten cycles at most plus program steps stay far below this
    localparam int MAX_CYCLES = 20000;
    localparam int HOST_LINES = 1024;

    logic     clk = 1'b0;
    logic     rstn;
    logic     cmd_valid;
    cmd_t     cmd;
    logic     cmd_ready;
    logic     done;
    logic     dma_valid;
    dma_req_t dma_req;
    logic     dma_ready;
    logic     dma_ack;
    laddr_t   dma_read_addr;
    line_t    dma_read_data;
    logic     dma_wvalid;
    line_t    dma_write_data;
    sram_wr_t sram_wr;
    sram_rd_t sram_rd;
    line_t    sram_rdata = '0;

    line_t    sram [0:4095];
    line_t    host [0:HOST_LINES-1];
    dma_req_t last_req;
    integer   seed = 32'hd915_e3fa;
    int       errors = 0;
    int       checks = 0;
    int       cycles = 0;
    int       done_seen = 0;
    int       beat_total = 0;
    word_t    r1;
    word_t    r2;
    word_t    r3;

    npu_core UUT (
        .clk            (clk),
        .rstn           (rstn),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .cmd_ready      (cmd_ready),
        .done           (done),
        .dma_valid      (dma_valid),
        .dma_req        (dma_req),
        .dma_ready      (dma_ready),
        .dma_ack        (dma_ack),
        .dma_read_addr  (dma_read_addr),
        .dma_read_data  (dma_read_data),
        .dma_wvalid     (dma_wvalid),
        .dma_write_data (dma_write_data),
        .sram_wr        (sram_wr),
        .sram_rd        (sram_rd),
        .sram_rdata     (sram_rdata)
    );

    bind npu_core npu_core_properties u_props (
        .clk            (clk),
        .rstn           (rstn),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .done           (done),
        .dma_valid      (dma_valid),
        .dma_req        (dma_req),
        .dma_ready      (dma_ready),
        .dma_ack        (dma_ack),
        .dma_wvalid     (dma_wvalid),
        .dma_write_data (dma_write_data),
        .sram_wr        (sram_wr),
        .sram_rd        (sram_rd)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // sram with one cycle read latency, read returns the old line
    always @(posedge clk)
    begin
        if (sram_rd.en)
            sram_rdata <= sram[sram_rd.addr];
        if (sram_wr.en)
            sram[sram_wr.addr] = sram_wr.data;
    end

    always @(negedge clk)
    begin
        if (rstn && done)
            done_seen++;
    end

    function automatic line_t fill_line(input int a);
        word_t w;
        w = word_t'(a) * 32'h9e37_79b9;
        return {w ^ 32'h5a5a_0000, w + word_t'(a), ~w, (word_t'(a) << 8) | word_t'(a)};
    endfunction

    function automatic int host_index(input haddr_t a, input int beat);
        return (int'(a[13:4]) + beat) % HOST_LINES;
    endfunction

    function automatic word_t encode_instr(input opcode_t op, input reg_idx_t a,
                                           input logic [19:0] imm);
        return {op, a, imm};
    endfunction

    function automatic line_t pack_line(input word_t w0, input word_t w1,
                                        input word_t w2, input word_t w3);
        return {w3, w2, w1, w0};
    endfunction

    task automatic check_line(input string what, input int index, input line_t got,
                              input line_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("error at %0d ns: %s[%0d] is %h, expected %h", $time, what, index,
                     got, exp);
        end
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // host side of a load with random gaps between beats
    task automatic feed_load(input dma_req_t r);
        int gap;
        for (int b = 0; b < int'(r.length); b++)
        begin
            gap = $unsigned($random(seed)) % 8;
            dma_ack = 1'b0;
            repeat (gap) @(negedge clk);
            dma_ack = 1'b1;
            dma_read_addr = laddr_t'(b);
            dma_read_data = host[host_index(r.host_addr, b)];
            beat_total++;
            @(negedge clk);
        end
        dma_ack = 1'b0;
    endtask

    // host side of a store with random ack stalls
    task automatic drain_store(input dma_req_t r);
        int cnt;
        cnt = 0;
        while (cnt < int'(r.length))
        begin
            dma_ack = ($unsigned($random(seed)) % 3) != 0;
            if (dma_ack && dma_wvalid)
            begin
                check_line("dma_write_data", cnt, dma_write_data,
                           sram[laddr_t'(r.local_addr + cnt)]);
                host[host_index(r.host_addr, cnt)] = dma_write_data;
                beat_total++;
                cnt++;
            end
            @(negedge clk);
        end
        dma_ack = 1'b0;
    endtask

    initial
    begin : host_model
        dma_req_t r;
        dma_ready = 1'b0;
        dma_ack = 1'b0;
        dma_read_addr = '0;
        dma_read_data = '0;
        forever
        begin
            @(negedge clk);
            dma_ready = dma_valid && (($unsigned($random(seed)) % 3) == 0);
            if (dma_ready)
            begin
                r = dma_req;
                last_req = r;
                @(negedge clk);
                dma_ready = 1'b0;
                if (r.write)
                    feed_load(r);
                else
                    drain_store(r);
            end
        end
    end

    task automatic run_cmd(input funct_t f, input haddr_t h, input laddr_t l, input len_t n,
                           input int exp_beats);
        beat_total = 0;
        cmd_valid = 1'b1;
        cmd.funct = f;
        cmd.host_addr = h;
        cmd.local_addr = l;
        cmd.length = n;
        while (!cmd_ready)
            @(negedge clk);
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd = '0;
        while (!done)
            @(negedge clk);
        check_value("beats at done", beat_total, exp_beats);
        @(negedge clk);
    endtask

    initial
    begin
        rstn = 1'b0;
        cmd_valid = 1'b0;
        cmd = '0;
        for (int i = 0; i < 4096; i++)
            sram[i] = fill_line(i);
        for (int i = 0; i < HOST_LINES; i++)
            host[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        // direct load of 12 lines
        run_cmd(FUNCT_LOAD, 40'h400, 12'h100, 16'd12, 12);
        for (int i = 0; i < 12; i++)
            check_line("sram", 12'h100 + i, sram[12'h100 + i], host[64 + i]);
        check_line("sram", 12'h10c, sram[12'h10c], fill_line(12'h10c));

        // direct store of 10 lines
        run_cmd(FUNCT_STORE, 40'h1000, 12'h300, 16'd10, 10);
        for (int i = 0; i < 10; i++)
            check_line("host", 256 + i, host[256 + i], sram[12'h300 + i]);

        // immediates feeding a store request
        sram[0] = pack_line(encode_instr(OPC_SETI, 4'd1, 20'hf1230),
                            encode_instr(OPC_SETI_HIGH, 4'd1, 20'h00000),
                            encode_instr(OPC_SETI, 4'd2, 20'h70040),
                            encode_instr(OPC_SETI_LOW, 4'd2, 20'h00050));
        sram[1] = pack_line(encode_instr(OPC_SETI, 4'd3, 20'h00060),
                            encode_instr(OPC_SETI_HIGH, 4'd3, 20'h00001),
                            encode_instr(OPC_STORE, 4'd1, {4'd2, 4'd3, 12'h000}),
                            encode_instr(OPC_RETURN, 4'd0, 20'h00000));
        r1 = {12'h000, 20'hf1230};
        r1[31:16] = 16'h0000;
        r2 = {12'h000, 20'h70040};
        r2[15:0] = 16'h0050;
        r3 = {12'h000, 20'h00060};
        r3[31:16] = 16'h0001;
        run_cmd(FUNCT_RUN, '0, '0, '0, 6);
        check_value("dma_req.write", last_req.write, 1'b0);
        check_value("dma_req.host_addr", last_req.host_addr, haddr_t'(r1));
        check_value("dma_req.local_addr", last_req.local_addr, r2[11:0]);
        check_value("dma_req.length", last_req.length, r3[15:0] / LINE_BYTES);

        // load then store to another host area
        sram[0] = pack_line(encode_instr(OPC_SETI, 4'd4, 20'h00200),
                            encode_instr(OPC_SETI, 4'd5, 20'h02000),
                            encode_instr(OPC_SETI, 4'd6, 20'h00050),
                            encode_instr(OPC_LOAD, 4'd4, {4'd5, 4'd6, 12'h000}));
        sram[1] = pack_line(encode_instr(OPC_SETI, 4'd7, 20'h03000),
                            encode_instr(OPC_NOP, 4'd0, 20'h00000),
                            encode_instr(OPC_STORE, 4'd7, {4'd4, 4'd6, 12'h000}),
                            encode_instr(OPC_RETURN, 4'd0, 20'h00000));
        run_cmd(FUNCT_RUN, '0, '0, '0, 10);
        for (int i = 0; i < 5; i++)
        begin
            check_line("sram", 12'h200 + i, sram[12'h200 + i], host[512 + i]);
            check_line("host", 768 + i, host[768 + i], host[512 + i]);
        end
        check_value("dma_req.host_addr", last_req.host_addr, 40'h3000);
        check_value("done pulses", done_seen, 4);

        @(negedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- testbench/npu_core_properties.sv
`timescale 1ns/1ps

module npu_core_properties
    import npu_pkg::*;
(
    input logic     clk,
    input logic     rstn,
    input logic     cmd_valid,
    input logic     cmd_ready,
    input logic     done,
    input logic     dma_valid,
    input dma_req_t dma_req,
    input logic     dma_ready,
    input logic     dma_ack,
    input logic     dma_wvalid,
    input line_t    dma_write_data,
    input sram_wr_t sram_wr,
    input sram_rd_t sram_rd
);

    // idle outputs on the edge after any reset edge
    reset_idle: assert property (@(posedge clk) !rstn |=>
        cmd_ready && !done && !dma_valid && !dma_wvalid && !sram_wr.en && !sram_rd.en)
        else $error("outputs not idle after reset");

    accept_drops_ready: assert property (@(posedge clk) disable iff (!rstn)
        cmd_valid && cmd_ready |=> !cmd_ready)
        else $error("cmd_ready still high after a command was accepted");

    ready_held_low: assert property (@(posedge clk) disable iff (!rstn)
        !cmd_ready && !done |=> !cmd_ready)
        else $error("cmd_ready rose before done");

    busy_at_done: assert property (@(posedge clk) disable iff (!rstn)
        done |-> !cmd_ready)
        else $error("cmd_ready high together with done");

    // single-cycle pulse, ready comes back right after
    done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        done |=> cmd_ready && !done)
        else $error("done longer than one cycle or cmd_ready late");

    req_stable: assert property (@(posedge clk) disable iff (!rstn)
        dma_valid && !dma_ready |=> dma_valid && $stable(dma_req))
        else $error("dma request changed while stalled");

    wdata_stable: assert property (@(posedge clk) disable iff (!rstn)
        dma_wvalid && !dma_ack |=> dma_wvalid && $stable(dma_write_data))
        else $error("store beat changed while stalled");

endmodule

//--- source/npu_core.sv
`timescale 1ns/1ps

module npu_core
    import npu_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     cmd_valid,
    input  cmd_t     cmd,
    output logic     cmd_ready,
    output logic     done,
    output logic     dma_valid,
    output dma_req_t dma_req,
    input  logic     dma_ready,
    input  logic     dma_ack,
    input  laddr_t   dma_read_addr,
    input  line_t    dma_read_data,
    output logic     dma_wvalid,
    output line_t    dma_write_data,
    output sram_wr_t sram_wr,
    output sram_rd_t sram_rd,
    input  line_t    sram_rdata
);

    word_t    instr;
    word_t    val_a;
    word_t    val_b;
    word_t    val_c;
    logic     fetch_start;
    logic     fetch_next;
    logic     rf_wr;
    logic     dma_start;
    dma_req_t dma_cmd;
    logic     dma_done;
    logic     eng_busy;
    sram_rd_t fetch_rd;
    sram_rd_t eng_rd;

    // engine owns the read port during a transfer
    assign sram_rd = eng_busy ? eng_rd : fetch_rd;

    npu_control u_control (
        .clk         (clk),
        .rstn        (rstn),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .cmd_ready   (cmd_ready),
        .done        (done),
        .instr       (instr),
        .val_a       (val_a),
        .val_b       (val_b),
        .val_c       (val_c),
        .fetch_start (fetch_start),
        .fetch_next  (fetch_next),
        .rf_wr       (rf_wr),
        .dma_start   (dma_start),
        .dma_cmd     (dma_cmd),
        .dma_done    (dma_done)
    );

    npu_fetch u_fetch (
        .clk   (clk),
        .rstn  (rstn),
        .start (fetch_start),
        .next  (fetch_next),
        .rdata (sram_rdata),
        .rd    (fetch_rd),
        .instr (instr)
    );

    npu_regfile u_regfile (
        .clk   (clk),
        .rstn  (rstn),
        .wr_en (rf_wr),
        .instr (instr),
        .val_a (val_a),
        .val_b (val_b),
        .val_c (val_c)
    );

    npu_dma_engine u_dma (
        .clk            (clk),
        .rstn           (rstn),
        .start          (dma_start),
        .req            (dma_cmd),
        .done           (dma_done),
        .dma_valid      (dma_valid),
        .dma_req        (dma_req),
        .dma_ready      (dma_ready),
        .dma_ack        (dma_ack),
        .dma_read_addr  (dma_read_addr),
        .dma_read_data  (dma_read_data),
        .dma_wvalid     (dma_wvalid),
        .dma_write_data (dma_write_data),
        .sram_wr        (sram_wr),
        .sram_rd        (eng_rd),
        .sram_rdata     (sram_rdata),
        .busy           (eng_busy)
    );

endmodule

//--- source/npu_control.sv
`timescale 1ns/1ps

module npu_control
    import npu_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     cmd_valid,
    input  cmd_t     cmd,
    output logic     cmd_ready,
    output logic     done,
    input  word_t    instr,
    input  word_t    val_a,
    input  word_t    val_b,
    input  word_t    val_c,
    output logic     fetch_start,
    output logic     fetch_next,
    output logic     rf_wr,
    output logic     dma_start,
    output dma_req_t dma_cmd,
    input  logic     dma_done
);

    ctrl_state_t state;
    opcode_t     op_q;
    logic        prog;
    logic        accept;
    logic        direct;
    logic        op_dma;

    assign cmd_ready   = state == IDLE;
    assign done        = state == DONE;
    assign accept      = cmd_valid && cmd_ready;
    assign direct      = cmd.funct == FUNCT_LOAD || cmd.funct == FUNCT_STORE;
    assign op_dma      = op_q == OPC_LOAD || op_q == OPC_STORE;
    assign fetch_start = accept && cmd.funct == FUNCT_RUN;
    assign fetch_next  = state == FETCH;
    assign rf_wr       = state == EXEC;
    assign dma_start   = (accept && direct) || (state == EXEC && op_dma);

    always_comb
    begin
        if (state == IDLE)
        begin
            dma_cmd.write      = cmd.funct == FUNCT_LOAD;
            dma_cmd.host_addr  = cmd.host_addr;
            dma_cmd.local_addr = cmd.local_addr;
            dma_cmd.length     = cmd.length;
        end
        else
        begin
            // load is a=local b=host, store swaps them; c is a byte count
            dma_cmd.write      = op_q == OPC_LOAD;
            dma_cmd.host_addr  = haddr_t'(op_q == OPC_LOAD ? val_b : val_a);
            dma_cmd.local_addr = op_q == OPC_LOAD ? val_a[LADDR_W-1:0] : val_b[LADDR_W-1:0];
            dma_cmd.length     = len_t'(val_c[LEN_W-1:0] / LINE_BYTES);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state <= IDLE;
            prog  <= 1'b0;
            op_q  <= OPC_NOP;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        prog <= cmd.funct == FUNCT_RUN;
                        if (cmd.funct == FUNCT_RUN)
                            state <= FETCH;
                        else if (direct)
                            state <= DMA_WAIT;
                        else
                            state <= DONE;
                    end
                end
                FETCH:
                    state <= DECODE;
                DECODE:
                begin
                    op_q  <= instr[31:24];
                    state <= EXEC;
                end
                EXEC:
                begin
                    if (op_dma)
                        state <= DMA_WAIT;
                    else if (op_q == OPC_RETURN)
                        state <= DONE;
                    else
                        state <= FETCH;
                end
                DMA_WAIT:
                begin
                    if (dma_done)
                        state <= prog ? FETCH : DONE;
                end
                DONE:
                    state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

//--- source/npu_dma_engine.sv
`timescale 1ns/1ps

module npu_dma_engine
    import npu_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     start,
    input  dma_req_t req,
    output logic     done,
    output logic     dma_valid,
    output dma_req_t dma_req,
    input  logic     dma_ready,
    input  logic     dma_ack,
    input  laddr_t   dma_read_addr,
    input  line_t    dma_read_data,
    output logic     dma_wvalid,
    output line_t    dma_write_data,
    output sram_wr_t sram_wr,
    output sram_rd_t sram_rd,
    input  line_t    sram_rdata,
    output logic     busy
);

    dma_req_t req_q;
    len_t     beat_cnt;
    line_t    wdata_q;
    logic     xfer;
    logic     rd_req;
    logic     fresh;
    logic     beat;
    logic     last_beat;

    assign dma_req   = req_q;
    assign last_beat = len_t'(beat_cnt + 1'b1) == req_q.length;
    // loads never stall, stores need a line on the bus
    assign beat      = xfer && dma_ack && (req_q.write || dma_wvalid);

    assign sram_wr.en   = xfer && req_q.write && dma_ack;
    assign sram_wr.addr = laddr_t'(req_q.local_addr + dma_read_addr);
    assign sram_wr.data = dma_read_data;

    assign sram_rd.en   = rd_req;
    assign sram_rd.addr = laddr_t'(req_q.local_addr + beat_cnt[LADDR_W-1:0]);

    // first cycle after the read takes sram output directly
    assign dma_write_data = fresh ? sram_rdata : wdata_q;

    always_ff @(posedge clk)
    begin
        if (start && !busy)
            req_q <= req;
        if (fresh)
            wdata_q <= sram_rdata;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            busy       <= 1'b0;
            dma_valid  <= 1'b0;
            xfer       <= 1'b0;
            rd_req     <= 1'b0;
            fresh      <= 1'b0;
            dma_wvalid <= 1'b0;
            beat_cnt   <= '0;
            done       <= 1'b0;
        end
        else
        begin
            done   <= 1'b0;
            fresh  <= rd_req;
            rd_req <= 1'b0;
            if (start && !busy)
            begin
                busy      <= 1'b1;
                dma_valid <= 1'b1;
                beat_cnt  <= '0;
            end
            else if (dma_valid && dma_ready)
            begin
                dma_valid <= 1'b0;
                if (req_q.length == '0)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                else
                begin
                    xfer   <= 1'b1;
                    rd_req <= !req_q.write;
                end
            end
            if (rd_req)
                dma_wvalid <= 1'b1;
            if (beat)
            begin
                dma_wvalid <= 1'b0;
                beat_cnt   <= beat_cnt + 1'b1;
                if (last_beat)
                begin
                    xfer <= 1'b0;
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                else
                    rd_req <= !req_q.write;
            end
        end
    end

endmodule

//--- source/npu_regfile.sv
`timescale 1ns/1ps

module npu_regfile
    import npu_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  wr_en,
    input  word_t instr,
    output word_t val_a,
    output word_t val_b,
    output word_t val_c
);

    word_t          rf [1:NUM_REGS-1];
    opcode_t        opcode;
    reg_idx_t       idx_a;
    reg_idx_t       idx_b;
    reg_idx_t       idx_c;
    logic [19:0]    imm20;
    logic [15:0]    imm16;
    logic           a_ok;

    assign opcode = instr[31:24];
    assign idx_a  = instr[23:20];
    assign idx_b  = instr[19:16];
    assign idx_c  = instr[15:12];
    assign imm20  = instr[19:0];
    assign imm16  = instr[15:0];
    assign a_ok   = idx_a != '0 && idx_a < NUM_REGS;

    function automatic word_t read_reg(input reg_idx_t idx);
        word_t val;
        val = '0;
        // r0 and anything past r7 read as zero
        if (idx != '0 && idx < NUM_REGS)
            val = rf[idx[2:0]];
        return val;
    endfunction

    always_comb
    begin
        val_a = read_reg(idx_a);
        val_b = read_reg(idx_b);
        val_c = read_reg(idx_c);
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            for (int i = 1; i < NUM_REGS; i++)
                rf[i] <= '0;
        end
        else if (wr_en && a_ok)
        begin
            case (opcode)
                OPC_SETI:      rf[idx_a[2:0]] <= {12'h000, imm20};
                OPC_SETI_LOW:  rf[idx_a[2:0]] <= {rf[idx_a[2:0]][31:16], imm16};
                OPC_SETI_HIGH: rf[idx_a[2:0]] <= {imm16, rf[idx_a[2:0]][15:0]};
                default:       ;
            endcase
        end
    end

endmodule

//--- source/npu_fetch.sv
`timescale 1ns/1ps

module npu_fetch
    import npu_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     start,
    input  logic     next,
    input  line_t    rdata,
    output sram_rd_t rd,
    output word_t    instr
);

    laddr_t                              pc_line;
    logic [$clog2(WORDS_PER_LINE)-1:0]   pc_word;
    logic [$clog2(WORDS_PER_LINE)-1:0]   word_sel;
    logic                                pending;
    word_t                               instr_q;

    assign rd.en   = next;
    assign rd.addr = pc_line;

    // fresh word straight from sram, held copy afterwards
    assign instr = pending ? rdata[word_sel*REG_W +: REG_W] : instr_q;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            pc_line <= '0;
            pc_word <= '0;
            pending <= 1'b0;
        end
        else
        begin
            pending <= next;
            if (start)
            begin
                pc_line <= '0;
                pc_word <= '0;
            end
            else if (next)
            begin
                pc_word <= pc_word + 1'b1;
                if (pc_word == WORDS_PER_LINE - 1)
                    pc_line <= pc_line + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (next)
            word_sel <= pc_word;
        if (pending)
            instr_q <= instr;
    end

endmodule

//--- source/npu_pkg.sv
package npu_pkg;

    localparam int LINE_W         = 128;
    localparam int LINE_BYTES     = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int LADDR_W        = 12;
    localparam int HADDR_W        = 40;
    localparam int LEN_W          = 16;
    localparam int REG_W          = 32;
    localparam int NUM_REGS       = 8;
    localparam int FUNCT_W        = 7;

    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [LADDR_W-1:0] laddr_t;
    typedef logic [HADDR_W-1:0] haddr_t;
    typedef logic [LEN_W-1:0]   len_t;
    typedef logic [REG_W-1:0]   word_t;
    typedef logic [3:0]         reg_idx_t;
    typedef logic [7:0]         opcode_t;
    typedef logic [FUNCT_W-1:0] funct_t;

    localparam opcode_t OPC_NOP       = 8'h00;
    localparam opcode_t OPC_SETI      = 8'h02;
    localparam opcode_t OPC_SETI_LOW  = 8'h03;
    localparam opcode_t OPC_SETI_HIGH = 8'h04;
    localparam opcode_t OPC_LOAD      = 8'h07;
    localparam opcode_t OPC_STORE     = 8'h08;
    localparam opcode_t OPC_RETURN    = 8'hff;

    localparam funct_t FUNCT_RUN   = 7'd2;
    localparam funct_t FUNCT_LOAD  = 7'd3;
    localparam funct_t FUNCT_STORE = 7'd4;

    typedef enum logic [2:0] {IDLE, FETCH, DECODE, EXEC, DMA_WAIT, DONE} ctrl_state_t;

    typedef struct packed {
        funct_t funct;
        haddr_t host_addr;
        laddr_t local_addr;
        len_t   length;
    } cmd_t;

    // write set means host to sram
    typedef struct packed {
        logic   write;
        haddr_t host_addr;
        laddr_t local_addr;
        len_t   length;
    } dma_req_t;

    typedef struct packed {
        logic   en;
        laddr_t addr;
        line_t  data;
    } sram_wr_t;

    typedef struct packed {
        logic   en;
        laddr_t addr;
    } sram_rd_t;

endpackage
